/* dotPkg.sv */
`default_nettype none

package dotPkg;

	localparam int numLanes = 4;  // multiplier lanes
	localparam int widthX = 8;
	localparam int widthY = 8;
	localparam int widthP = widthX + widthY;  // full signed product
	localparam int accWidth = 24;  // accumulator wraps at this width
	localparam int wbAddrWidth = 4;  // word address
	localparam int wbDataWidth = 32;
	localparam int speedSel = 1;  // 0 ripple, 1 brent-kung, 2 sklansky

	// word address map
	localparam int addrOperand0 = 0;  // lane i sits at addrOperand0 + i
	localparam int addrControl = 4;
	localparam int addrResult = 5;

	// control and status bits
	localparam int ctrlStartBit = 0;
	localparam int ctrlAccBit = 1;
	localparam int statDoneBit = 0;  // same word, read side

	typedef logic [widthX-1:0] opX;
	typedef logic [widthY-1:0] opY;
	typedef logic [widthP-1:0] prodT;
	typedef logic [accWidth-1:0] accT;
	typedef logic [wbAddrWidth-1:0] wbAddrT;
	typedef logic [wbDataWidth-1:0] wbDataT;

	typedef enum logic {idle, ackPhase} wbState;  // slave handshake

endpackage

`default_nettype wire

/* csaCells.sv */
`timescale 1ns/1ps
`default_nettype none

module fullAdder (
	input  logic A,
	input  logic B,
	input  logic CI,
	output logic S,
	output logic CO
);

	logic halfSum;  // a xor b, shared by sum and carry

	assign halfSum = A ^ B;
	assign S = halfSum ^ CI;
	assign CO = (A & B) | (halfSum & CI);

endmodule

// one column of an (m,2) compressor
module cpr #(
	parameter int depth = 4,  // bits in this column
	parameter int speed = 0
) (
	input  logic [depth-1:0] A,
	input  logic [depth-4:0] CI,  // carries from the column below
	output logic             S,
	output logic             C,
	output logic [depth-4:0] CO  // carries to the column above
);

	// queue of bits still to be summed, adders append their sums at the end
	logic [3*depth-6:0] fifo;
	logic [depth-3:0] carryOut;

	assign fifo[depth-1:0] = A;

	if (speed == 0) begin : chain
		fullAdder fa0 (.A(fifo[0]), .B(fifo[1]), .CI(fifo[2]), .S(fifo[depth]), .CO(carryOut[0]));
		for (genvar i = 1; i < depth-2; i++) begin : stage
			// one new input bit, one carry, previous sum
			fullAdder fa (
				.A (fifo[i+2]),
				.B (CI[i-1]),
				.CI(fifo[depth+2*(i-1)]),
				.S (fifo[depth+2*i]),
				.CO(carryOut[i])
			);
		end
	end else begin : tree
		for (genvar i = 0; i < depth-2; i++) begin : stage
			fullAdder fa (
				.A (fifo[3*i]),
				.B (fifo[3*i+1]),
				.CI(fifo[3*i+2]),
				.S (fifo[depth+2*i]),
				.CO(carryOut[i])
			);
			if (i < depth-3) begin : carrySlot
				assign fifo[depth+2*i+1] = CI[i];  // carry joins the queue
			end
		end
	end

	assign CO = carryOut[depth-4:0];
	assign C = carryOut[depth-3];  // weight +1, leaves via carry vector
	assign S = fifo[3*depth-6];  // last sum written

endmodule

// multi-operand carry-save adder
module addMopCsv #(
	parameter int width = 8,
	parameter int depth = 4,  // operand count, at least 4
	parameter int speed = 0
) (
	input  logic [depth*width-1:0] A,  // operand k at bits k*width
	output logic [width-1:0]       S,
	output logic [width-1:0]       C  // already shifted by one
);

	logic [depth*width-1:0] columns;  // bits regrouped by weight
	logic [(depth-3)*(width+1)-1:0] carryChain;
	logic [width-1:0] carryRaw;

	always_comb begin
		for (int i = 0; i < width; i++) begin
			for (int k = 0; k < depth; k++) begin
				columns[i*depth+k] = A[k*width+i];
			end
		end
	end

	assign carryChain[depth-4:0] = '0;  // lsb column

	for (genvar i = 0; i < width; i++) begin : slices
		cpr #(.depth(depth), .speed(speed)) slice (
			.A (columns[i*depth +: depth]),
			.CI(carryChain[i*(depth-3) +: depth-3]),
			.S (S[i]),
			.C (carryRaw[i]),
			.CO(carryChain[(i+1)*(depth-3) +: depth-3])  // top slice overflow dropped
		);
	end

	assign C = {carryRaw[width-2:0], 1'b0};

endmodule

`default_nettype wire

/* prefixAdd.sv */
`timescale 1ns/1ps
`default_nettype none

// prefix and-or tree for carry lookahead
module prefixAndOr #(
	parameter int width = 8,
	parameter int speed = 0  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI,
	input  logic [width-1:0] PI,
	output logic [width-1:0] GO,
	output logic [width-1:0] PO
);

	localparam int m = $clog2(width);  // levels of the up sweep

	if (speed == 0) begin : serial
		logic [width-1:0] gT;
		logic [width-1:0] pT;

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];
		for (genvar j = 1; j < width; j++) begin : bits
			assign gT[j] = GI[j] | (PI[j] & gT[j-1]);
			assign pT[j] = PI[j] & pT[j-1];
		end
		assign GO = gT;
		assign PO = pT;
	end else if (speed == 1) begin : brentKung
		// level 0 is the input, m up levels, m-1 down levels
		logic [width-1:0] gT [0:2*m-1];
		logic [width-1:0] pT [0:2*m-1];

		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l < 2*m; l++) begin : levels
			localparam int span = (l <= m) ? 2**l : 2**(2*m-l);
			for (genvar j = 0; j < width; j++) begin : bits
				// up sweep closes aligned blocks, down sweep fills the gaps
				localparam bit upNode = (l <= m) && ((j+1) % span == 0);
				localparam bit downNode = (l > m) && ((j+1) % span == span/2) && (j >= span);
				if (upNode || downNode) begin : black
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][j-span/2]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][j-span/2];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end
		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];
	end else begin : sklansky
		logic [width-1:0] gT [0:m];
		logic [width-1:0] pT [0:m];

		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar j = 0; j < width; j++) begin : bits
				if (((j >> (l-1)) & 1) == 1) begin : black
					// top of the lower half block, fans out to the upper half
					localparam int src = ((j >> (l-1)) << (l-1)) - 1;
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end
		assign GO = gT[m];
		assign PO = pT[m];
	end

endmodule

// carry propagate adder, modulo 2**width
module add #(
	parameter int width = 8,
	parameter int speed = 0
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	output logic [width-1:0] S
);

	if (speed == 0) begin : plain
		assign S = A + B;  // left to synthesis
	end else begin : prefix
		logic [width-1:0] gen;
		logic [width-1:0] prop;
		logic [width-1:0] halfSum;
		logic [width-1:0] carry;  // carry out of each bit

		assign gen = A & B;
		assign prop = A | B;  // or-propagate is enough for carries
		assign halfSum = ~gen & prop;  // a xor b

		prefixAndOr #(.width(width), .speed(speed)) tree (
			.GI(gen),
			.PI(prop),
			.GO(carry),
			.PO()
		);

		assign S = halfSum ^ {carry[width-2:0], 1'b0};
	end

endmodule

`default_nettype wire

/* mulSgn.sv */
`timescale 1ns/1ps
`default_nettype none

// baugh-wooley rows for a signed widthX by widthY product
module mulPPGenSgn import dotPkg::*; (
	input  opX X,
	input  opY Y,
	output logic [(widthX+2)*widthP-1:0] PP  // row r at bits r*widthP
);

	always_comb begin
		logic [widthP-1:0] rows [widthX+2];

		for (int r = 0; r < widthX+2; r++) begin
			rows[r] = '0;
		end
		// plain rows, msb of y enters inverted sense
		for (int i = 0; i < widthX-1; i++) begin
			for (int k = 0; k < widthY-1; k++) begin
				rows[i][i+k] = X[i] & Y[k];
			end
			rows[i][i+widthY-1] = ~X[i] & Y[widthY-1];
		end
		// sign row of x
		for (int k = 0; k < widthY-1; k++) begin
			rows[widthX-1][widthX-1+k] = X[widthX-1] & ~Y[k];
		end
		rows[widthX-1][widthP-2] = X[widthX-1] & Y[widthY-1];  // sign times sign
		// correction ones and sign terms
		rows[widthX][widthP-2] = ~X[widthX-1];
		rows[widthX][widthX-1] = X[widthX-1];
		rows[widthX+1][widthP-1] = 1'b1;
		rows[widthX+1][widthP-2] = ~Y[widthY-1];
		rows[widthX+1][widthY-1] = Y[widthY-1];
		for (int r = 0; r < widthX+2; r++) begin
			PP[r*widthP +: widthP] = rows[r];
		end
	end

endmodule

// one lane, purely combinational
module mulSgn import dotPkg::*; (
	input  opX   X,
	input  opY   Y,
	output prodT P
);

	logic [(widthX+2)*widthP-1:0] partials;
	prodT sumVec;
	prodT carryVec;

	mulPPGenSgn ppGen (.X(X), .Y(Y), .PP(partials));

	addMopCsv #(.width(widthP), .depth(widthX+2), .speed(speedSel)) csa (
		.A(partials),
		.S(sumVec),
		.C(carryVec)
	);

	add #(.width(widthP), .speed(speedSel)) cpa (.A(sumVec), .B(carryVec), .S(P));

endmodule

`default_nettype wire

/* wbDotRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module wbDotRegs import dotPkg::*; (
	input  logic                         clk,
	input  logic                         arstN,
	input  logic                         wbCyc,
	input  logic                         wbStb,
	input  logic                         wbWe,
	input  wbAddrT                       wbAddr,
	input  wbDataT                       wbDatIn,
	output wbDataT                       wbDatOut,
	output logic                         wbAck,
	output logic [numLanes*widthX-1:0]   opXBus,
	output logic [numLanes*widthY-1:0]   opYBus,
	output logic                         go,  // one cycle, one per start
	output logic                         accMode,
	input  accT                          result,
	input  logic                         done,
	output logic                         resultRead  // clears done in dotReduce
);

	wbState state;
	wbAddrT addrQ;  // address of the access being acked
	logic accept;
	logic ctrlWr;
	logic startReq;  // start seen, go follows one cycle later

	assign accept = (state == idle) && wbCyc && wbStb;
	assign ctrlWr = accept && wbWe && (wbAddr == wbAddrT'(addrControl));
	assign resultRead = accept && !wbWe && (wbAddr == wbAddrT'(addrResult));
	assign wbAck = (state == ackPhase);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			addrQ <= '0;
		end else begin
			case (state)
				idle: begin
					if (accept) begin
						state <= ackPhase;
					end
				end
				ackPhase: state <= idle;  // master drops stb after ack
				default: state <= idle;
			endcase
			if (accept) begin
				addrQ <= wbAddr;
			end
		end
	end

	// operand and control writes on the accept edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opXBus <= '0;
			opYBus <= '0;
			accMode <= 1'b0;
			startReq <= 1'b0;
			go <= 1'b0;
		end else begin
			for (int i = 0; i < numLanes; i++) begin
				if (accept && wbWe && (wbAddr == wbAddrT'(addrOperand0 + i))) begin
					opXBus[i*widthX +: widthX] <= wbDatIn[widthX-1:0];
					opYBus[i*widthY +: widthY] <= wbDatIn[widthX +: widthY];
				end
			end
			if (ctrlWr) begin
				accMode <= wbDatIn[ctrlAccBit];
			end
			startReq <= ctrlWr && wbDatIn[ctrlStartBit];
			go <= startReq;  // back to back starts stay separate pulses
		end
	end

	// read data, valid while ack is high
	always_comb begin
		wbDatOut = '0;  // unmapped words
		for (int i = 0; i < numLanes; i++) begin
			if (addrQ == wbAddrT'(addrOperand0 + i)) begin
				wbDatOut[widthX-1:0] = opXBus[i*widthX +: widthX];
				wbDatOut[widthX +: widthY] = opYBus[i*widthY +: widthY];
			end
		end
		if (addrQ == wbAddrT'(addrControl)) begin
			wbDatOut[statDoneBit] = done;
		end else if (addrQ == wbAddrT'(addrResult)) begin
			wbDatOut = {{(wbDataWidth-accWidth){result[accWidth-1]}}, result};  // sign ext
		end
	end

endmodule

`default_nettype wire

/* dotReduce.sv */
`timescale 1ns/1ps
`default_nettype none

module dotReduce import dotPkg::*; (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic [numLanes*widthP-1:0]  prodBus,
	input  logic                        go,
	input  logic                        accMode,  // add held accumulator
	output accT                         result,
	output logic                        done,
	input  logic                        resultRead
);

	logic [(numLanes+1)*accWidth-1:0] operands;  // lanes, then accumulator
	accT sumVec;
	accT carryVec;
	accT total;

	always_comb begin
		for (int i = 0; i < numLanes; i++) begin
			operands[i*accWidth +: accWidth] =
				{{(accWidth-widthP){prodBus[i*widthP+widthP-1]}}, prodBus[i*widthP +: widthP]};
		end
		operands[numLanes*accWidth +: accWidth] = accMode ? result : '0;
	end

	addMopCsv #(.width(accWidth), .depth(numLanes+1), .speed(speedSel)) csa (
		.A(operands),
		.S(sumVec),
		.C(carryVec)
	);

	add #(.width(accWidth), .speed(speedSel)) cpa (.A(sumVec), .B(carryVec), .S(total));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			done <= 1'b0;
		end else if (go) begin
			result <= total;  // wraps mod 2**accWidth
			done <= 1'b1;  // a new result beats a read on the same edge
		end else if (resultRead) begin
			done <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* dotTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dotTop import dotPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  logic   wbCyc,
	input  logic   wbStb,
	input  logic   wbWe,
	input  wbAddrT wbAddr,
	input  wbDataT wbDatIn,
	output wbDataT wbDatOut,
	output logic   wbAck
);

	logic [numLanes*widthX-1:0] opXBus;
	logic [numLanes*widthY-1:0] opYBus;
	logic [numLanes*widthP-1:0] prodBus;
	logic go;
	logic accMode;
	logic done;
	logic resultRead;
	accT result;

	wbDotRegs regs (
		.clk       (clk),
		.arstN     (arstN),
		.wbCyc     (wbCyc),
		.wbStb     (wbStb),
		.wbWe      (wbWe),
		.wbAddr    (wbAddr),
		.wbDatIn   (wbDatIn),
		.wbDatOut  (wbDatOut),
		.wbAck     (wbAck),
		.opXBus    (opXBus),
		.opYBus    (opYBus),
		.go        (go),
		.accMode   (accMode),
		.result    (result),
		.done      (done),
		.resultRead(resultRead)
	);

	for (genvar i = 0; i < numLanes; i++) begin : lanes
		mulSgn lane (
			.X(opXBus[i*widthX +: widthX]),
			.Y(opYBus[i*widthY +: widthY]),
			.P(prodBus[i*widthP +: widthP])
		);
	end

	dotReduce reduce (
		.clk       (clk),
		.arstN     (arstN),
		.prodBus   (prodBus),
		.go        (go),
		.accMode   (accMode),
		.result    (result),
		.done      (done),
		.resultRead(resultRead)
	);

endmodule

`default_nettype wire

/* tbDot.sv */
`timescale 1ns/1ps
`default_nettype none

module tbDot import dotPkg::*; ;

	localparam int resetCycles = 8;
	localparam int cyclesPerAccess = 8;  // gap up to 3, drive, ack, drop
	// 2 reset reads, 9 readback, 20 random, 4 extreme, 8 chained, 4 done
	localparam int numAccesses = 2 + 9 + 20*6 + 4*6 + 8*6 + 4 + 4;
	localparam int cycleLimit = numAccesses*cyclesPerAccess + resetCycles;

	logic clk;
	logic arstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	wbAddrT wbAddr;
	wbDataT wbDatIn;
	wbDataT wbDatOut;
	logic wbAck;

	logic [31:0] lfsrState = 32'hb68ff899;
	int cycleCount = 0;
	int dataErrors = 0;
	int flagErrors = 0;

	opX laneX [numLanes];  // model copy of the operand registers
	opY laneY [numLanes];
	accT accModel;  // last result the DUT should hold

	dotTop i_dut (
		.clk     (clk),
		.arstN   (arstN),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbWe    (wbWe),
		.wbAddr  (wbAddr),
		.wbDatIn (wbDatIn),
		.wbDatOut(wbDatOut),
		.wbAck   (wbAck)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// galois form, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};  // one step per bit
		end
		return v;
	endfunction

	// signed value of an 8 bit operand
	function automatic int toInt(input logic [7:0] v);
		return v[7] ? int'(v) - 256 : int'(v);
	endfunction

	function automatic int laneSum();
		int s;
		s = 0;
		for (int i = 0; i < numLanes; i++) begin
			s += toInt(laneX[i]) * toInt(laneY[i]);
		end
		return s;
	endfunction

	// 24 bit result as a signed 32 bit word
	function automatic wbDataT signExtend(input accT v);
		int s;
		s = v[accWidth-1] ? int'(v) - (1 << accWidth) : int'(v);
		return wbDataT'(s);
	endfunction

	task automatic checkData(input string name, input wbDataT expected, input wbDataT actual);
		if (expected !== actual) begin
			dataErrors++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			flagErrors++;
			$display("[ERROR] %s expected %b actual %b", name, expected, actual);
		end
	endtask

	// one classic cycle, random idle gap first
	task automatic busAccess(input logic we, input wbAddrT addr, input wbDataT wdata,
			output wbDataT rdata);
		int gap;
		gap = randBits(2);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		wbCyc <= 1'b1;
		wbStb <= 1'b1;
		wbWe <= we;
		wbAddr <= addr;
		wbDatIn <= wdata;
		@(negedge clk);
		while (!wbAck) @(negedge clk);  // slave acks the cycle after it sees stb
		rdata = wbDatOut;  // stable mid cycle
		@(posedge clk);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe <= 1'b0;
	endtask

	task automatic wbWrite(input wbAddrT addr, input wbDataT data);
		wbDataT unused;
		busAccess(1'b1, addr, data, unused);
	endtask

	task automatic wbRead(input wbAddrT addr, output wbDataT data);
		busAccess(1'b0, addr, '0, data);
	endtask

	task automatic loadOperands();
		for (int i = 0; i < numLanes; i++) begin
			wbWrite(wbAddrT'(addrOperand0 + i), {16'h0, laneY[i], laneX[i]});
		end
	endtask

	// start, update model, read result back
	task automatic runDot(input string name, input logic accumulate);
		wbDataT rd;
		wbDataT ctrl;
		loadOperands();
		ctrl = '0;
		ctrl[ctrlStartBit] = 1'b1;
		ctrl[ctrlAccBit] = accumulate;
		wbWrite(wbAddrT'(addrControl), ctrl);
		if (accumulate) accModel = accModel + accT'(laneSum());  // wraps at 24 bits
		else accModel = accT'(laneSum());
		wbRead(wbAddrT'(addrResult), rd);
		checkData(name, signExtend(accModel), rd);
	endtask

	task automatic setAllLanes(input opX x, input opY y);
		for (int i = 0; i < numLanes; i++) begin
			laneX[i] = x;
			laneY[i] = y;
		end
	endtask

	// hang guard
	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, bus access never finished", cycleCount);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		wbDataT rd;
		wbDataT wdata;
		wbDataT ctrl;
		arstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAddr = '0;
		wbDatIn = '0;
		accModel = '0;
		setAllLanes('0, '0);
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;

		// 1. reset state
		repeat (3) begin
			@(negedge clk);
			checkFlag("idleAck", 1'b0, wbAck);
		end
		wbRead(wbAddrT'(addrControl), rd);
		checkData("resetControl", '0, rd);
		wbRead(wbAddrT'(addrResult), rd);
		checkData("resetResult", '0, rd);

		// 2. operand readback, upper bits random on write
		for (int i = 0; i < numLanes; i++) begin
			wdata = randBits(32);
			laneX[i] = wdata[7:0];
			laneY[i] = wdata[15:8];
			wbWrite(wbAddrT'(addrOperand0 + i), wdata);
		end
		for (int i = 0; i < numLanes; i++) begin
			wbRead(wbAddrT'(addrOperand0 + i), rd);
			checkData("operandReadback", {16'h0, laneY[i], laneX[i]}, rd);
		end
		@(posedge clk);
		wbStb <= 1'b1;  // no cyc
		wbAddr <= wbAddrT'(addrControl);
		repeat (6) begin
			@(negedge clk);
			checkFlag("stbWithoutCyc", 1'b0, wbAck);
		end
		@(posedge clk);
		wbStb <= 1'b0;

		// 3. random dot products
		for (int n = 0; n < 20; n++) begin
			for (int i = 0; i < numLanes; i++) begin
				laneX[i] = randBits(8);
				laneY[i] = randBits(8);
			end
			runDot("randomDot", 1'b0);
		end

		// 4. corner operands on every lane
		setAllLanes(8'h80, 8'h80);
		runDot("minTimesMin", 1'b0);
		setAllLanes(8'h80, 8'h7f);
		runDot("minTimesMax", 1'b0);
		setAllLanes(8'h00, 8'h80);
		runDot("zeroTimesMin", 1'b0);
		setAllLanes(8'h7f, 8'h7f);
		runDot("maxTimesMax", 1'b0);

		// 5. accumulate chain, starts from the last result
		for (int n = 0; n < 8; n++) begin
			for (int i = 0; i < numLanes; i++) begin
				laneX[i] = randBits(8);
				laneY[i] = randBits(8);
			end
			runDot("accChain", 1'b1);
		end

		// 6. done flag set by start, cleared by result read
		ctrl = '0;
		ctrl[ctrlStartBit] = 1'b1;
		wbWrite(wbAddrT'(addrControl), ctrl);
		accModel = accT'(laneSum());
		wbRead(wbAddrT'(addrControl), rd);
		checkFlag("doneAfterStart", 1'b1, rd[statDoneBit]);
		wbRead(wbAddrT'(addrResult), rd);
		checkData("doneResult", signExtend(accModel), rd);
		wbRead(wbAddrT'(addrControl), rd);
		checkFlag("doneAfterRead", 1'b0, rd[statDoneBit]);

		repeat (2) @(posedge clk);
		$display("errors: data %0d, flag %0d", dataErrors, flagErrors);
		if (dataErrors == 0 && flagErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
dotPkg.sv
csaCells.sv
prefixAdd.sv
mulSgn.sv
wbDotRegs.sv
dotReduce.sv
dotTop.sv
tbDot.sv
